// File: logic/video_pkg.sv
package video_pkg;

	////////////////////
	// Widths and codes
	////////////////////
	typedef logic [10:0] coord_t;   // Pixel or line count
	typedef logic [3:0]  sw_code_t; // Raw switch code
	typedef logic [7:0]  color_t;   // One colour component

	// Switch codes as wired on the board
	typedef enum sw_code_t {
		MODE_VGA      = 4'b0000,
		MODE_SVGA     = 4'b0001,
		MODE_HDTV720P = 4'b0010,
		MODE_XGA      = 4'b0011,
		MODE_SXGA     = 4'b1000,
		MODE_CAMERA   = 4'b1001
	} mode_t;

	typedef struct packed {
		color_t r;
		color_t g;
		color_t b;
	} rgb_t;

	typedef struct packed {
		coord_t hpixels;       // Live pixels
		coord_t hfnprch;       // Front porch
		coord_t hsyncpw;       // Sync width
		coord_t hbkprch;       // Back porch
		coord_t vlines;        // Live lines
		coord_t vfnprch;
		coord_t vsyncpw;
		coord_t vbkprch;
		coord_t bar_width;     // Active width / 8
		logic   sync_negative; // 1 = active low syncs
	} timing_t;

	////////////////////
	// Mode timing table
	////////////////////
	function automatic timing_t make_timing(
		input coord_t hpix, input coord_t hfp, input coord_t hsw, input coord_t hbp,
		input coord_t vlin, input coord_t vfp, input coord_t vsw, input coord_t vbp,
		input logic   neg
	);
		timing_t t;
		t.hpixels       = hpix;
		t.hfnprch       = hfp;
		t.hsyncpw       = hsw;
		t.hbkprch       = hbp;
		t.vlines        = vlin;
		t.vfnprch       = vfp;
		t.vsyncpw       = vsw;
		t.vbkprch       = vbp;
		t.bar_width     = hpix >> 3; // Eight equal bars
		t.sync_negative = neg;
		return t;
	endfunction

	function automatic timing_t mode_timing(input mode_t mode);
		case (mode)
			MODE_VGA:    return make_timing(640, 16, 96, 48, 480, 11, 2, 31, 1'b1);    // 640x480
			MODE_SVGA:   return make_timing(800, 40, 128, 88, 600, 1, 4, 23, 1'b0);    // 800x600
			MODE_XGA:    return make_timing(1024, 24, 136, 160, 768, 3, 6, 29, 1'b1);  // 1024x768
			MODE_SXGA:   return make_timing(1280, 48, 112, 248, 1024, 1, 3, 38, 1'b0); // 1280x1024
			MODE_CAMERA: return make_timing(1280, 110, 39, 220, 720, 4, 4, 22, 1'b0);
			default:     return make_timing(1280, 110, 40, 220, 720, 5, 5, 20, 1'b0); // 720p
		endcase
	endfunction

	////////////////////
	// Colour bars
	////////////////////
	localparam color_t C_ON  = 8'hFF;
	localparam color_t C_OFF = 8'h00;

	// Left to right
	localparam rgb_t BAR_COLORS [0:7] = '{
		'{C_ON,  C_ON,  C_ON},  // White
		'{C_ON,  C_ON,  C_OFF}, // Yellow
		'{C_OFF, C_ON,  C_ON},  // Cyan
		'{C_OFF, C_ON,  C_OFF}, // Green
		'{C_ON,  C_OFF, C_ON},  // Magenta
		'{C_ON,  C_OFF, C_OFF}, // Red
		'{C_OFF, C_OFF, C_ON},  // Blue
		'{C_OFF, C_OFF, C_OFF}  // Black
	};

endpackage

// File: logic/mode_select.sv
`timescale 1ns/1ps

module mode_select
	import video_pkg::*;
#(
	parameter int DEBOUNCE_BITS = 16 // Stable time is 2**DEBOUNCE_BITS cycles
) (
	input  logic     clk50m_bufg,
	input  logic     RSTBTN,
	input  sw_code_t sw,          // Raw board switches
	output mode_t    active_mode,
	output timing_t  timing,      // Timing record of active_mode
	output logic     restart      // One cycle on mode change
);

	sw_code_t sw_meta;  // First sync stage
	sw_code_t sw_sync;  // Second sync stage
	sw_code_t sw_hold;  // Code under debounce
	logic [DEBOUNCE_BITS-1:0] stable_cnt;
	logic     stable;
	mode_t    new_mode;

	// Unlisted codes run as 720p
	function automatic mode_t decode_mode(input sw_code_t code);
		case (code)
			MODE_VGA, MODE_SVGA, MODE_XGA, MODE_SXGA, MODE_CAMERA:
				return mode_t'(code);
			default:
				return MODE_HDTV720P;
		endcase
	endfunction

	////////////////////
	// Synchronizer
	////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			sw_meta <= sw_code_t'(MODE_HDTV720P); // Power-up mode
			sw_sync <= sw_code_t'(MODE_HDTV720P);
		end else begin
			sw_meta <= sw;
			sw_sync <= sw_meta;
		end
	end

	////////////////////
	// Debounce
	////////////////////
	// Whole code must sit still, any bit change restarts the count
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			sw_hold    <= sw_code_t'(MODE_HDTV720P);
			stable_cnt <= '0;
		end else if (sw_sync != sw_hold) begin
			sw_hold    <= sw_sync; // New candidate
			stable_cnt <= '0;
		end else if (!stable) begin
			stable_cnt <= stable_cnt + 1'b1;
		end
	end

	assign stable   = &stable_cnt;          // Counter saturated
	assign new_mode = decode_mode(sw_hold);

	////////////////////
	// Mode register
	////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			active_mode <= MODE_HDTV720P;
			timing      <= mode_timing(MODE_HDTV720P);
			restart     <= 1'b0;
		end else begin
			restart <= 1'b0; // Default low
			if (stable && (new_mode != active_mode)) begin
				active_mode <= new_mode;
				timing      <= mode_timing(new_mode); // Table lookup
				restart     <= 1'b1;                  // Raster back to 0,0
			end
		end
	end

endmodule

// File: logic/raster_timing.sv
`timescale 1ns/1ps

module raster_timing
	import video_pkg::*;
(
	input  logic    clk50m_bufg,
	input  logic    RSTBTN,
	input  logic    restart,   // Mode change
	input  timing_t timing,
	output coord_t  hcount,
	output coord_t  vcount,
	output logic    hblnk,
	output logic    vblnk,
	output logic    hsync_int, // Active high
	output logic    vsync_int  // Active high
);

	coord_t h_sync_beg;
	coord_t h_sync_end;
	coord_t h_total;
	coord_t v_sync_beg;
	coord_t v_sync_end;
	coord_t v_total;
	logic   h_last;
	logic   v_last;

	////////////////////
	// Edge positions
	////////////////////
	// Live area, front porch, sync, back porch
	assign h_sync_beg = timing.hpixels + timing.hfnprch;
	assign h_sync_end = h_sync_beg + timing.hsyncpw;      // First pixel after sync
	assign h_total    = h_sync_end + timing.hbkprch;      // Pixels per line

	assign v_sync_beg = timing.vlines + timing.vfnprch;
	assign v_sync_end = v_sync_beg + timing.vsyncpw;
	assign v_total    = v_sync_end + timing.vbkprch;      // Lines per frame

	// Greater-equal so a stray count still wraps
	assign h_last = (hcount >= h_total - 11'd1);
	assign v_last = (vcount >= v_total - 11'd1);

	////////////////////
	// Counters
	////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN || restart) begin
			hcount <= '0;
			vcount <= '0;
		end else if (h_last) begin
			hcount <= '0; // New line
			if (v_last)
				vcount <= '0; // New frame
			else
				vcount <= vcount + 11'd1;
		end else begin
			hcount <= hcount + 11'd1;
		end
	end

	////////////////////
	// Flags
	////////////////////
	assign hblnk = (hcount >= timing.hpixels);
	assign vblnk = (vcount >= timing.vlines);

	// Width is exactly hsyncpw / vsyncpw
	assign hsync_int = (hcount >= h_sync_beg) && (hcount < h_sync_end);
	assign vsync_int = (vcount >= v_sync_beg) && (vcount < v_sync_end);

endmodule

// File: logic/video_output.sv
`timescale 1ns/1ps

module video_output
	import video_pkg::*;
(
	input  logic    clk50m_bufg,
	input  logic    RSTBTN,
	input  timing_t timing,
	input  coord_t  hcount,
	input  logic    hblnk,
	input  logic    vblnk,
	input  logic    hsync_int,
	input  logic    vsync_int,
	output logic    hsync,     // Polarity corrected
	output logic    vsync,
	output logic    de,
	output rgb_t    pixel
);

	logic       hsync_q;  // Stage 1
	logic       vsync_q;
	logic       de_q;
	coord_t     col_cnt;  // hcount mod bar_width
	logic [2:0] bar_idx;  // hcount / bar_width

	////////////////////
	// Stage 1
	////////////////////
	// Sync XOR polarity, DE from both blanks
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			hsync_q <= 1'b0;
			vsync_q <= 1'b0;
			de_q    <= 1'b0;
		end else begin
			hsync_q <= hsync_int ^ timing.sync_negative;
			vsync_q <= vsync_int ^ timing.sync_negative;
			de_q    <= !hblnk && !vblnk;
		end
	end

	// Running bar position, tracks hcount one cycle behind
	// Raster steps by one every cycle, so no divider
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN || (hcount == '0)) begin
			col_cnt <= '0; // Line start
			bar_idx <= '0;
		end else if (col_cnt == timing.bar_width - 11'd1) begin
			col_cnt <= '0;
			bar_idx <= bar_idx + 3'd1; // Next bar, wraps in blanking
		end else begin
			col_cnt <= col_cnt + 11'd1;
		end
	end

	////////////////////
	// Stage 2
	////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			hsync <= 1'b0;
			vsync <= 1'b0;
			de    <= 1'b0;
			pixel <= '0;
		end else begin
			hsync <= hsync_q;
			vsync <= vsync_q;
			de    <= de_q;
			pixel <= de_q ? BAR_COLORS[bar_idx] : '0; // Black outside live area
		end
	end

endmodule

// File: logic/video_timing_top.sv
`timescale 1ns/1ps

module video_timing_top
	import video_pkg::*;
#(
	parameter int DEBOUNCE_BITS = 16 // Switch debounce length, log2 cycles
) (
	input  logic     clk50m_bufg,
	input  logic     RSTBTN,
	input  sw_code_t sw,
	output logic     hsync,
	output logic     vsync,
	output logic     de,
	output rgb_t     pixel,
	output mode_t    active_mode
);

	timing_t timing;     // Active mode record
	logic    restart;
	coord_t  hcount;
	coord_t  vcount;     // Line count, probed by the testbench
	logic    hblnk;
	logic    vblnk;
	logic    hsync_int;
	logic    vsync_int;

	////////////////////
	// Mode selection
	////////////////////
	mode_select #(
		.DEBOUNCE_BITS(DEBOUNCE_BITS)
	) mode_select_i (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.sw          (sw),
		.active_mode (active_mode),
		.timing      (timing),
		.restart     (restart)
	);

	////////////////////
	// Raster counters
	////////////////////
	raster_timing raster_timing_i (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.restart     (restart),
		.timing      (timing),
		.hcount      (hcount),
		.vcount      (vcount),
		.hblnk       (hblnk),
		.vblnk       (vblnk),
		.hsync_int   (hsync_int),
		.vsync_int   (vsync_int)
	);

	////////////////////
	// Sync, DE, bars
	////////////////////
	video_output video_output_i (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.timing      (timing),
		.hcount      (hcount),
		.hblnk       (hblnk),
		.vblnk       (vblnk),
		.hsync_int   (hsync_int),
		.vsync_int   (vsync_int),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de),
		.pixel       (pixel)
	);

endmodule

// File: bench/video_timing_properties.sv
`timescale 1ns/1ps

module video_timing_properties
	import video_pkg::*;
(
	input logic clk50m_bufg,
	input logic RSTBTN,
	input logic restart,
	input logic hsync,
	input logic de,
	input rgb_t pixel
);

	int unsigned fail_count = 0; // Failed property count

	// Black outside the live area
	pixel_black: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		!de |-> (pixel == '0))
	else begin
		$error("pixel not black while DE is low");
		fail_count++;
	end

	// Sync edges only in blanking, restart transient excluded
	hsync_edge_in_blank: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		((hsync != $past(hsync)) && !$past(restart, 2) && !$past(restart, 3))
		|-> (!de && (de == $past(de))))
	else begin
		$error("DE moved with an hsync edge");
		fail_count++;
	end

	hsync_hold: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		((hsync != $past(hsync)) && !$past(restart, 2) && !$past(restart, 3))
		|=> (hsync == $past(hsync)))
	else begin
		$error("hsync level held for a single cycle");
		fail_count++;
	end

	restart_pulse: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		restart |=> !restart)
	else begin
		$error("restart longer than one cycle");
		fail_count++;
	end

endmodule

bind video_timing_top video_timing_properties props_i (
	.clk50m_bufg (clk50m_bufg),
	.RSTBTN      (RSTBTN),
	.restart     (restart),
	.hsync       (hsync),
	.de          (de),
	.pixel       (pixel)
);

// File: bench/tb_video_timing.sv
`timescale 1ns/1ps

module tb_video_timing
	import video_pkg::*;
();

	localparam int SEL_H = 0;
	localparam int SEL_V = 1;
	localparam int SEL_DE = 2;
	localparam int WAIT_LIMIT = 2_000_000; // Above one 720p frame
	localparam int MODE_LIMIT = 1000;      // Sync plus debounce, with margin

	typedef struct packed {
		logic hsync;
		logic vsync;
		logic de;
		rgb_t pixel;
		logic pix_chk; // Pixel is comparable
	} vid_exp_t;

	logic     clk50m_bufg = 1'b0;
	logic     RSTBTN;
	sw_code_t sw;
	logic     hsync;
	logic     vsync;
	logic     de;
	rgb_t     pixel;
	mode_t    active_mode;
	string    test_name = "reset";

	// Model state, one step per clock
	coord_t   m_h = '0;
	coord_t   m_v = '0;
	timing_t  m_t = mode_timing(MODE_HDTV720P);
	mode_t    prev_mode = MODE_HDTV720P;
	logic     rst_edge = 1'b1;     // RSTBTN seen by the coming edge
	logic     restart_edge = 1'b0; // Raster restarts at the coming edge
	vid_exp_t stage1 = '0;
	vid_exp_t stage2 = '0;

	video_timing_top #(.DEBOUNCE_BITS(4)) dut_i (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.sw          (sw),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de),
		.pixel       (pixel),
		.active_mode (active_mode)
	);

	always #10 clk50m_bufg = ~clk50m_bufg; // 50 MHz

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string what, input int expected, input int actual);
		assert (actual == expected) else
			stop_run($sformatf("MISMATCH %s %s expected %0d actual %0d",
				test_name, what, expected, actual));
	endtask

	function automatic logic probe(input int sel);
		case (sel)
			SEL_H:   return hsync;
			SEL_V:   return vsync;
			default: return de;
		endcase
	endfunction

	////////////////////
	// Reference model
	////////////////////
	function automatic vid_exp_t reference_outputs(input coord_t h, input coord_t v,
			input timing_t t);
		vid_exp_t e;
		int hs_beg;
		int vs_beg;
		int idx;
		hs_beg = t.hpixels + t.hfnprch; // Sync starts after front porch
		vs_beg = t.vlines + t.vfnprch;
		e = '0;
		e.pix_chk = 1'b1;
		e.hsync = ((h >= hs_beg) && (h < hs_beg + t.hsyncpw)) ^ t.sync_negative;
		e.vsync = ((v >= vs_beg) && (v < vs_beg + t.vsyncpw)) ^ t.sync_negative;
		e.de = (h < t.hpixels) && (v < t.vlines);
		if (e.de) begin
			idx = h / t.bar_width;
			// White, yellow, cyan, green, magenta, red, blue, black
			e.pixel.r = idx[1] ? 8'h00 : 8'hFF;
			e.pixel.g = idx[2] ? 8'h00 : 8'hFF;
			e.pixel.b = idx[0] ? 8'h00 : 8'hFF;
		end
		return e;
	endfunction

	// Model advance and compare, mid-cycle where outputs are settled
	always @(negedge clk50m_bufg) begin
		int h_total;
		int v_total;
		h_total = m_t.hpixels + m_t.hfnprch + m_t.hsyncpw + m_t.hbkprch;
		v_total = m_t.vlines + m_t.vfnprch + m_t.vsyncpw + m_t.vbkprch;
		if (rst_edge) begin
			stage1 = '0;
			stage1.pix_chk = 1'b1; // Black in reset
			stage2 = stage1;
			m_h = '0;
			m_v = '0;
		end else begin
			stage2 = stage1;                            // Output is two cycles behind
			stage1 = reference_outputs(m_h, m_v, m_t);
			if (restart_edge) begin
				stage1.pix_chk = 1'b0; // Old position under the new bar width
				m_h = '0;
				m_v = '0;
			end else if (m_h == h_total - 1) begin
				m_h = '0;
				m_v = (m_v == v_total - 1) ? '0 : m_v + 11'd1;
			end else begin
				m_h = m_h + 11'd1;
			end
		end
		restart_edge = !rst_edge && (active_mode != prev_mode); // Mode just changed
		prev_mode = active_mode;
		m_t = mode_timing(active_mode);
		rst_edge = RSTBTN;
		check_value("hsync", stage2.hsync, hsync);
		check_value("vsync", stage2.vsync, vsync);
		check_value("de", stage2.de, de);
		if (stage2.pix_chk)
			check_value("pixel", stage2.pixel, pixel);
		// Raster position against the model
		check_value("hcount", m_h, dut_i.hcount);
		check_value("vcount", m_v, dut_i.vcount);
		assert (dut_i.props_i.fail_count == 0) else
			stop_run("a bound timing property failed");
	end

	////////////////////
	// Waits and measures
	////////////////////
	task automatic wait_level(input int sel, input logic level);
		int n;
		n = 0;
		while (probe(sel) != level) begin
			@(negedge clk50m_bufg);
			n++;
			if (n > WAIT_LIMIT)
				stop_run($sformatf("timeout waiting for an output level in test %s", test_name));
		end
	endtask

	// Drive switches, wait for the new mode, let the pipeline settle
	task automatic select_mode(input sw_code_t code, input mode_t expected);
		int n;
		n = 0;
		@(posedge clk50m_bufg);
		#2 sw = code;
		while (active_mode != expected) begin
			@(negedge clk50m_bufg);
			n++;
			if (n > MODE_LIMIT)
				stop_run($sformatf("timeout waiting for the mode change in test %s", test_name));
		end
		repeat (4) @(negedge clk50m_bufg);
	endtask

	// One pulse at level, its period, and DE rises inside that period
	task automatic measure_pulse(input int sel, input logic level,
			output int width, output int period, output int de_rises);
		logic de_prev;
		logic left;
		wait_level(sel, !level);
		wait_level(sel, level); // Pulse start
		width = 0;
		period = 0;
		de_rises = 0;
		left = 1'b0;
		de_prev = de;
		while (!left || (probe(sel) != level)) begin
			if (probe(sel) != level)
				left = 1'b1;
			else if (!left)
				width++;
			if (de && !de_prev)
				de_rises++;
			de_prev = de;
			period++;
			@(negedge clk50m_bufg);
			if (period > WAIT_LIMIT)
				stop_run($sformatf("timeout measuring a pulse in test %s", test_name));
		end
	endtask

	////////////////////
	// Stimulus
	////////////////////
	initial begin
		int w;
		int p;
		int n;
		RSTBTN = 1'b1;
		sw = sw_code_t'(MODE_HDTV720P); // Same as reset mode
		repeat (10) @(posedge clk50m_bufg);
		#2 RSTBTN = 1'b0;
		@(negedge clk50m_bufg);
		check_value("active_mode", MODE_HDTV720P, active_mode);
		check_value("de", 0, de);
		check_value("pixel", 0, pixel);
		check_value("hsync", 0, hsync);
		check_value("vsync", 0, vsync);

		test_name = "vga";
		select_mode(4'b0000, MODE_VGA);
		measure_pulse(SEL_H, 1'b0, w, p, n);
		check_value("hsync low width", 96, w);
		check_value("line total", 800, p);
		measure_pulse(SEL_DE, 1'b1, w, p, n);
		check_value("active pixels per line", 640, w);
		measure_pulse(SEL_V, 1'b0, w, p, n);
		check_value("vsync low width", 2 * 800, w); // Two lines
		check_value("frame total", 524 * 800, p);
		check_value("active lines", 480, n);

		test_name = "svga";
		select_mode(4'b0001, MODE_SVGA);
		measure_pulse(SEL_H, 1'b1, w, p, n);
		check_value("hsync high width", 128, w);
		check_value("hsync period", 1056, p);

		test_name = "undefined code";
		select_mode(4'b0111, MODE_HDTV720P);
		measure_pulse(SEL_H, 1'b1, w, p, n);
		check_value("hsync high width", 40, w);
		check_value("hsync period", 1650, p);

		// Short VGA blip, below the debounce time
		test_name = "glitch";
		@(posedge clk50m_bufg);
		#2 sw = 4'b0000;
		repeat (3) @(posedge clk50m_bufg);
		#2 sw = 4'b0111;
		repeat (40) begin
			@(negedge clk50m_bufg);
			check_value("active_mode", MODE_HDTV720P, active_mode);
		end
		measure_pulse(SEL_H, 1'b1, w, p, n);
		check_value("hsync period", 1650, p);

		$display("All checks passed");
		$finish;
	end

endmodule

// File: files.f
logic/video_pkg.sv
logic/mode_select.sv
logic/raster_timing.sv
logic/video_output.sv
logic/video_timing_top.sv
bench/video_timing_properties.sv
bench/tb_video_timing.sv

// File: Makefile
TOP       ?= tb_video_timing
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then exit 1; fi
	@if ! grep -q "All checks passed" $(LOG); then echo "no result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
